// ==== hdl/lsq_pkg.sv ====
// Widths, depths, operation encoding and entry formats of the load/store ordering block
// Imported by every RTL module that handles memory instructions and by the testbench
package lsq_pkg;

    localparam int LSQ_ENTRIES = 4;   // Load/store queue depth
    localparam int SB_ENTRIES  = 2;   // Store buffer depth
    localparam int ADDR_W      = 8;   // Word address
    localparam int DATA_W      = 32;
    localparam int TAG_W       = 4;   // Instruction tag from the core

    typedef enum logic {
        MEM_LOAD  = 1'b0,
        MEM_STORE = 1'b1
    } mem_op_t;

    // Instruction as held in the load/store queue
    typedef struct packed {
        mem_op_t           op;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic [TAG_W-1:0]  tag;
    } lsq_entry_t;

    // Store waiting in the store buffer
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic [TAG_W-1:0]  tag;
        logic              committed;   // Set once the core has committed the store
    } sb_entry_t;

endpackage

// ==== hdl/mem_circ_queue.sv ====
// Circular buffer of any entry type, with all slots visible for associative search
// Backs both the load/store queue and the store buffer
`timescale 1ns/1ps

module mem_circ_queue #(
    parameter type entry_t = logic [7:0],
    parameter int  DEPTH   = 4
) (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  logic                   clear_i,     // Drop every entry
    input  logic                   push_i,
    input  entry_t                 push_data_i,
    input  logic                   pop_i,
    output entry_t                 head_o,
    output logic                   full_o,
    output logic                   empty_o,
    output entry_t                 entries_o [DEPTH],   // Indexed by physical slot
    output logic [DEPTH-1:0]       valid_o
);

    entry_t mem_q [DEPTH];

    logic [$clog2(DEPTH)-1:0] head_q;
    logic [$clog2(DEPTH)-1:0] tail_q;
    logic [$clog2(DEPTH):0]   count_q;   // One bit wider than the pointers

    logic do_push;
    logic do_pop;

    assign full_o  = (count_q == DEPTH);
    assign empty_o = (count_q == '0);
    assign do_push = push_i & ~full_o;
    assign do_pop  = pop_i & ~empty_o;

    assign head_o    = mem_q[head_q];
    assign entries_o = mem_q;

    // A slot is valid when it lies less than count places after the head
    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            valid_o[i] = ((i + DEPTH - int'(head_q)) % DEPTH) < int'(count_q);
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[tail_q] <= push_data_i;
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (clear_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (do_push) begin
                tail_q <= (tail_q == DEPTH - 1) ? '0 : tail_q + 1'b1;
            end
            if (do_pop) begin
                head_q <= (head_q == DEPTH - 1) ? '0 : head_q + 1'b1;
            end
            count_q <= count_q + {{$clog2(DEPTH){1'b0}}, do_push}
                               - {{$clog2(DEPTH){1'b0}}, do_pop};
        end
    end

endmodule

// ==== hdl/store_buffer.sv ====
// Buffer of stores that left the queue, waiting for their commit before going to memory
// Also flags head loads that hit a buffered store address
`timescale 1ns/1ps

module store_buffer
    import lsq_pkg::*;
(
    input  logic              clk_i,
    input  logic              rstn_i,
    input  logic              flush_i,
    input  logic              push_i,
    input  lsq_entry_t        push_entry_i,
    input  logic              commit_valid_i,
    input  logic [TAG_W-1:0]  commit_tag_i,
    input  logic              pop_i,
    input  logic [ADDR_W-1:0] load_addr_i,
    output sb_entry_t         head_o,
    output logic              head_ready_o,   // Head store is committed
    output logic              full_o,
    output logic              empty_o,
    output logic              collision_o
);

    sb_entry_t sb_entries [SB_ENTRIES];
    sb_entry_t push_data;
    sb_entry_t q_head;

    logic [SB_ENTRIES-1:0] sb_valid;
    logic [SB_ENTRIES-1:0] cmt_q;       // Commits that arrived after the push
    logic [SB_ENTRIES-1:0] dead_q;      // Discarded by a flush, popped when at head
    logic [SB_ENTRIES-1:0] live;
    logic [SB_ENTRIES-1:0] committed;
    logic [SB_ENTRIES-1:0] tag_hit;
    logic [SB_ENTRIES-1:0] addr_hit;

    logic [2**TAG_W-1:0]          pend_q;       // Commits seen while the store was still queued
    logic [$clog2(SB_ENTRIES)-1:0] head_idx_q;  // Physical slot of the head

    logic q_empty;
    logic q_pop;
    logic q_clear;
    logic push_hit;
    logic head_dead;

    always_comb begin
        for (int i = 0; i < SB_ENTRIES; i++) begin
            live[i]      = sb_valid[i] & ~dead_q[i];
            committed[i] = sb_entries[i].committed | cmt_q[i];
            tag_hit[i]   = commit_valid_i & live[i] & (sb_entries[i].tag == commit_tag_i);
            addr_hit[i]  = live[i] & (sb_entries[i].addr == load_addr_i);
        end
    end

    // Commit in the push cycle, or earlier while the store sat in the queue
    assign push_hit  = commit_valid_i & push_i & (push_entry_i.tag == commit_tag_i);
    assign push_data = '{addr:      push_entry_i.addr,
                         wdata:     push_entry_i.wdata,
                         tag:       push_entry_i.tag,
                         committed: push_hit | pend_q[push_entry_i.tag]};

    assign head_dead = dead_q[head_idx_q];
    assign q_pop     = pop_i | (~q_empty & head_dead);
    // Full clear only when no committed store has to survive the flush
    assign q_clear   = flush_i & ~|(live & (committed | tag_hit));

    mem_circ_queue #(
        .entry_t (sb_entry_t),
        .DEPTH   (SB_ENTRIES)
    ) u_sb_queue (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .clear_i     (q_clear),
        .push_i      (push_i),
        .push_data_i (push_data),
        .pop_i       (q_pop),
        .head_o      (q_head),
        .full_o      (full_o),
        .empty_o     (q_empty),
        .entries_o   (sb_entries),
        .valid_o     (sb_valid)
    );

    always_comb begin
        head_o           = q_head;
        head_o.committed = committed[head_idx_q];
    end

    assign head_ready_o = ~q_empty & ~head_dead & committed[head_idx_q];
    assign empty_o      = ~|live;
    assign collision_o  = |addr_hit;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            cmt_q      <= '0;
            dead_q     <= '0;
            pend_q     <= '0;
            head_idx_q <= '0;
        end else begin
            // Per-slot flags die with their entry
            for (int i = 0; i < SB_ENTRIES; i++) begin
                cmt_q[i]  <= sb_valid[i] & (cmt_q[i] | tag_hit[i]);
                dead_q[i] <= sb_valid[i] & (dead_q[i] | (flush_i & ~committed[i] & ~tag_hit[i]));
            end
            if (q_clear) begin
                head_idx_q <= '0;
            end else if (q_pop && !q_empty) begin
                head_idx_q <= (head_idx_q == SB_ENTRIES - 1) ? '0 : head_idx_q + 1'b1;
            end
            if (flush_i) begin
                pend_q <= '0;
            end else begin
                if (commit_valid_i && !(|tag_hit) && !push_hit) begin
                    pend_q[commit_tag_i] <= 1'b1;   // Store not here yet
                end
                if (push_i) begin
                    pend_q[push_entry_i.tag] <= 1'b0;
                end
            end
        end
    end

endmodule

// ==== hdl/load_store_queue.sv ====
// In-order memory instruction queue with its store buffer
// Sends head stores to the buffer and picks the next operation for the memory port
`timescale 1ns/1ps

module load_store_queue
    import lsq_pkg::*;
(
    input  logic              clk_i,
    input  logic              rstn_i,
    input  logic              flush_i,
    input  logic              instr_valid_i,
    input  mem_op_t           instr_op_i,
    input  logic [ADDR_W-1:0] instr_addr_i,
    input  logic [DATA_W-1:0] instr_wdata_i,
    input  logic [TAG_W-1:0]  instr_tag_i,
    input  logic              commit_valid_i,
    input  logic [TAG_W-1:0]  commit_tag_i,
    input  logic              issue_ready_i,
    output logic              issue_valid_o,
    output mem_op_t           issue_op_o,
    output logic [ADDR_W-1:0] issue_addr_o,
    output logic [DATA_W-1:0] issue_wdata_o,
    output logic [TAG_W-1:0]  issue_tag_o,
    output logic              full_o,
    output logic              empty_o,
    output logic              load_after_store_o
);

    lsq_entry_t q_head;
    lsq_entry_t q_push_data;
    sb_entry_t  sb_head;

    logic q_full;
    logic q_empty;
    logic q_push;
    logic q_pop;
    logic sb_head_ready;
    logic sb_full;
    logic sb_empty;
    logic sb_collision;
    logic sb_push;
    logic sb_pop;
    logic head_load;
    logic head_store;
    logic issue_sb;
    logic issue_load;

    assign q_push      = instr_valid_i & ~full_o;
    assign q_push_data = '{op:    instr_op_i,
                           addr:  instr_addr_i,
                           wdata: instr_wdata_i,
                           tag:   instr_tag_i};

    mem_circ_queue #(
        .entry_t (lsq_entry_t),
        .DEPTH   (LSQ_ENTRIES)
    ) u_lsq_queue (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .clear_i     (flush_i),
        .push_i      (q_push),
        .push_data_i (q_push_data),
        .pop_i       (q_pop),
        .head_o      (q_head),
        .full_o      (q_full),
        .empty_o     (q_empty),
        .entries_o   (),
        .valid_o     ()
    );

    store_buffer u_store_buffer (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .flush_i        (flush_i),
        .push_i         (sb_push),
        .push_entry_i   (q_head),
        .commit_valid_i (commit_valid_i),
        .commit_tag_i   (commit_tag_i),
        .pop_i          (sb_pop),
        .load_addr_i    (q_head.addr),
        .head_o         (sb_head),
        .head_ready_o   (sb_head_ready),
        .full_o         (sb_full),
        .empty_o        (sb_empty),
        .collision_o    (sb_collision)
    );

    assign head_load  = ~q_empty & (q_head.op == MEM_LOAD);
    assign head_store = ~q_empty & (q_head.op == MEM_STORE);

    // Head store moves on its own, without the memory port
    assign sb_push = head_store & ~sb_full & ~flush_i;

    // Committed stores first, then a head load with no buffered match
    assign issue_sb      = sb_head_ready;
    assign issue_load    = ~issue_sb & head_load & ~sb_collision & ~flush_i;
    assign issue_valid_o = issue_sb | issue_load;

    always_comb begin
        if (issue_sb) begin
            issue_op_o    = MEM_STORE;
            issue_addr_o  = sb_head.addr;
            issue_wdata_o = sb_head.wdata;
            issue_tag_o   = sb_head.tag;
        end else begin
            issue_op_o    = q_head.op;
            issue_addr_o  = q_head.addr;
            issue_wdata_o = q_head.wdata;
            issue_tag_o   = q_head.tag;
        end
    end

    assign sb_pop = issue_sb & issue_ready_i;
    assign q_pop  = sb_push | (issue_load & issue_ready_i);

    assign full_o             = q_full | flush_i;   // No new instruction while flushing
    assign empty_o            = q_empty & sb_empty;
    assign load_after_store_o = head_load & sb_collision;

endmodule

// ==== hdl/mem_wb_master.sv ====
// Memory port that runs one Wishbone classic cycle per granted operation
// Returns load data as a one-cycle pulse after the ack
`timescale 1ns/1ps

module mem_wb_master
    import lsq_pkg::*;
(
    input  logic              clk_i,
    input  logic              rstn_i,
    input  logic              flush_i,
    input  logic              issue_valid_i,
    input  mem_op_t           issue_op_i,
    input  logic [ADDR_W-1:0] issue_addr_i,
    input  logic [DATA_W-1:0] issue_wdata_i,
    input  logic [TAG_W-1:0]  issue_tag_i,
    output logic              issue_ready_o,
    output logic              wb_cyc_o,
    output logic              wb_stb_o,
    output logic              wb_we_o,
    output logic [ADDR_W-1:0] wb_adr_o,
    output logic [DATA_W-1:0] wb_dat_o,
    input  logic [DATA_W-1:0] wb_dat_i,
    input  logic              wb_ack_i,
    output logic              load_valid_o,
    output logic [TAG_W-1:0]  load_tag_o,
    output logic [DATA_W-1:0] load_data_o
);

    logic             busy_q;     // Idle when low
    logic             cancel_q;   // Flush seen during the running cycle
    mem_op_t          op_q;
    logic [TAG_W-1:0] tag_q;
    logic             accept;
    logic             done;

    assign issue_ready_o = ~busy_q;
    assign accept        = issue_valid_i & ~busy_q;
    assign done          = busy_q & wb_ack_i;

    assign wb_cyc_o = busy_q;
    assign wb_stb_o = busy_q;
    assign wb_we_o  = (op_q == MEM_STORE);

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            busy_q       <= 1'b0;
            cancel_q     <= 1'b0;
            load_valid_o <= 1'b0;
        end else begin
            load_valid_o <= done & (op_q == MEM_LOAD) & ~cancel_q & ~flush_i;
            if (accept) begin
                busy_q   <= 1'b1;
                cancel_q <= 1'b0;
            end else if (done) begin
                busy_q   <= 1'b0;   // Bus idles at least one cycle
                cancel_q <= 1'b0;
            end else if (busy_q && flush_i) begin
                cancel_q <= 1'b1;
            end
        end
    end

    // Operation held stable for the whole bus cycle
    always_ff @(posedge clk_i) begin
        if (accept) begin
            op_q     <= issue_op_i;
            tag_q    <= issue_tag_i;
            wb_adr_o <= issue_addr_i;
            wb_dat_o <= issue_wdata_i;
        end
        if (done) begin
            load_data_o <= wb_dat_i;
            load_tag_o  <= tag_q;
        end
    end

endmodule

// ==== hdl/data_ram.sv ====
// Word-addressed data RAM behind a Wishbone classic slave port
// Cleared by reset, registered ack one cycle after the strobe is first seen
`timescale 1ns/1ps

module data_ram
    import lsq_pkg::*;
(
    input  logic              clk_i,
    input  logic              rstn_i,
    input  logic              wb_cyc_i,
    input  logic              wb_stb_i,
    input  logic              wb_we_i,
    input  logic [ADDR_W-1:0] wb_adr_i,
    input  logic [DATA_W-1:0] wb_dat_i,
    output logic [DATA_W-1:0] wb_dat_o,
    output logic              wb_ack_o
);

    logic [DATA_W-1:0] mem_q [2**ADDR_W];
    logic              req;

    assign req = wb_cyc_i & wb_stb_i & ~wb_ack_o;   // First strobe cycle only

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < 2**ADDR_W; i++) begin
                mem_q[i] <= '0;
            end
            wb_ack_o <= 1'b0;
            wb_dat_o <= '0;
        end else begin
            wb_ack_o <= req;
            if (req) begin
                if (wb_we_i) begin
                    mem_q[wb_adr_i] <= wb_dat_i;
                end else begin
                    wb_dat_o <= mem_q[wb_adr_i];
                end
            end
        end
    end

endmodule

// ==== hdl/lsq_top.sv ====
// Memory-ordering block of the load/store unit with its data RAM
// Queue feeds the Wishbone memory port, which drives the RAM
`timescale 1ns/1ps

module lsq_top
    import lsq_pkg::*;
(
    input  logic              clk_i,
    input  logic              rstn_i,
    input  logic              instr_valid_i,
    input  mem_op_t           instr_op_i,
    input  logic [ADDR_W-1:0] instr_addr_i,
    input  logic [DATA_W-1:0] instr_wdata_i,
    input  logic [TAG_W-1:0]  instr_tag_i,
    input  logic              commit_valid_i,
    input  logic [TAG_W-1:0]  commit_tag_i,
    input  logic              flush_i,
    output logic              full_o,
    output logic              empty_o,
    output logic              load_valid_o,
    output logic [TAG_W-1:0]  load_tag_o,
    output logic [DATA_W-1:0] load_data_o,
    output logic              load_after_store_o
);

    // Queue to memory port
    logic              issue_valid;
    logic              issue_ready;
    mem_op_t           issue_op;
    logic [ADDR_W-1:0] issue_addr;
    logic [DATA_W-1:0] issue_wdata;
    logic [TAG_W-1:0]  issue_tag;

    // Memory port to RAM
    logic              wb_cyc;
    logic              wb_stb;
    logic              wb_we;
    logic              wb_ack;
    logic [ADDR_W-1:0] wb_adr;
    logic [DATA_W-1:0] wb_dat_w;
    logic [DATA_W-1:0] wb_dat_r;

    load_store_queue u_lsq (
        .clk_i              (clk_i),
        .rstn_i             (rstn_i),
        .flush_i            (flush_i),
        .instr_valid_i      (instr_valid_i),
        .instr_op_i         (instr_op_i),
        .instr_addr_i       (instr_addr_i),
        .instr_wdata_i      (instr_wdata_i),
        .instr_tag_i        (instr_tag_i),
        .commit_valid_i     (commit_valid_i),
        .commit_tag_i       (commit_tag_i),
        .issue_ready_i      (issue_ready),
        .issue_valid_o      (issue_valid),
        .issue_op_o         (issue_op),
        .issue_addr_o       (issue_addr),
        .issue_wdata_o      (issue_wdata),
        .issue_tag_o        (issue_tag),
        .full_o             (full_o),
        .empty_o            (empty_o),
        .load_after_store_o (load_after_store_o)
    );

    mem_wb_master u_mem_port (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .flush_i       (flush_i),
        .issue_valid_i (issue_valid),
        .issue_op_i    (issue_op),
        .issue_addr_i  (issue_addr),
        .issue_wdata_i (issue_wdata),
        .issue_tag_i   (issue_tag),
        .issue_ready_o (issue_ready),
        .wb_cyc_o      (wb_cyc),
        .wb_stb_o      (wb_stb),
        .wb_we_o       (wb_we),
        .wb_adr_o      (wb_adr),
        .wb_dat_o      (wb_dat_w),
        .wb_dat_i      (wb_dat_r),
        .wb_ack_i      (wb_ack),
        .load_valid_o  (load_valid_o),
        .load_tag_o    (load_tag_o),
        .load_data_o   (load_data_o)
    );

    data_ram u_data_ram (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .wb_cyc_i (wb_cyc),
        .wb_stb_i (wb_stb),
        .wb_we_i  (wb_we),
        .wb_adr_i (wb_adr),
        .wb_dat_i (wb_dat_w),
        .wb_dat_o (wb_dat_r),
        .wb_ack_o (wb_ack)
    );

endmodule

// ==== tests/lsq_assert.sv ====
// Protocol checks on the load/store queue, attached by bind to every load_store_queue
// Covers issue gating in a flush, full/empty consistency and blocked head loads
`timescale 1ns/1ps

module lsq_assert
    import lsq_pkg::*;
(
    input logic    clk_i,
    input logic    rstn_i,
    input logic    flush_i,
    input logic    issue_valid_i,
    input mem_op_t issue_op_i,
    input logic    full_i,
    input logic    empty_i,
    input logic    las_i        // Head load blocked by a buffered store
);

    int fail_count = 0;

    // Nothing to issue when the queue is both full and empty, which only a flush produces
    assert property (@(posedge clk_i) disable iff (!rstn_i)
        (full_i && empty_i) |-> !$rose(issue_valid_i))
        else begin
            fail_count++;
            $error("issue_valid rose while full and empty were both high");
        end

    assert property (@(posedge clk_i) disable iff (!rstn_i)
        !flush_i |-> !(full_i && empty_i))
        else begin
            fail_count++;
            $error("full and empty both high outside a flush");
        end

    // Blocked head load must not reach the memory port
    assert property (@(posedge clk_i) disable iff (!rstn_i)
        las_i |-> !(issue_valid_i && issue_op_i == MEM_LOAD))
        else begin
            fail_count++;
            $error("load issued while load_after_store was high");
        end

endmodule

bind load_store_queue lsq_assert u_lsq_assert (
    .clk_i         (clk_i),
    .rstn_i        (rstn_i),
    .flush_i       (flush_i),
    .issue_valid_i (issue_valid_o),
    .issue_op_i    (issue_op_o),
    .full_i        (full_o),
    .empty_i       (empty_o),
    .las_i         (load_after_store_o)
);

// ==== tests/tb_lsq_top.sv ====
// Directed tests of the memory-ordering block against a reference memory model
// Inputs change on the falling edge, load results are checked in order as they return
`timescale 1ns/1ps

module tb_lsq_top
    import lsq_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 4000;   // All tests need well under 1000 cycles
    localparam int RAND_OPS       = 48;

    logic              clk_i;
    logic              rstn_i;
    logic              instr_valid_i;
    mem_op_t           instr_op_i;
    logic [ADDR_W-1:0] instr_addr_i;
    logic [DATA_W-1:0] instr_wdata_i;
    logic [TAG_W-1:0]  instr_tag_i;
    logic              commit_valid_i;
    logic [TAG_W-1:0]  commit_tag_i;
    logic              flush_i;
    logic              full_o;
    logic              empty_o;
    logic              load_valid_o;
    logic [TAG_W-1:0]  load_tag_o;
    logic [DATA_W-1:0] load_data_o;
    logic              load_after_store_o;

    logic [DATA_W-1:0] ref_mem [2**ADDR_W];   // Memory as seen by committed stores
    logic [TAG_W-1:0]  exp_tag_q [$];         // Outstanding loads, oldest first
    logic [DATA_W-1:0] exp_data_q [$];
    logic [31:0]       lfsr_q;
    logic [TAG_W-1:0]  next_tag;
    int                cycle_count = 0;

    lsq_top UUT (
        .clk_i              (clk_i),
        .rstn_i             (rstn_i),
        .instr_valid_i      (instr_valid_i),
        .instr_op_i         (instr_op_i),
        .instr_addr_i       (instr_addr_i),
        .instr_wdata_i      (instr_wdata_i),
        .instr_tag_i        (instr_tag_i),
        .commit_valid_i     (commit_valid_i),
        .commit_tag_i       (commit_tag_i),
        .flush_i            (flush_i),
        .full_o             (full_o),
        .empty_o            (empty_o),
        .load_valid_o       (load_valid_o),
        .load_tag_o         (load_tag_o),
        .load_data_o        (load_data_o),
        .load_after_store_o (load_after_store_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation finished: FAIL");
            $fatal(1, "Run stopped by timeout");
        end
    end

    task automatic report_error(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "Run stopped at first error");
    endtask

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    task automatic take_bits(input int nbits, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            value  = {value[30:0], lfsr_q[0]};
        end
    endtask

    task automatic new_tag(output logic [TAG_W-1:0] tag);
        tag      = next_tag;
        next_tag = next_tag + 1'b1;
    endtask

    // Results come back in program order
    always @(negedge clk_i) begin
        if (rstn_i && load_valid_o) begin
            assert (exp_tag_q.size() != 0)
                else report_error("load result arrived with no load outstanding");
            assert (load_tag_o == exp_tag_q[0] && load_data_o == exp_data_q[0])
                else report_error($sformatf("load tag %0d data %h, expected tag %0d data %h",
                                            load_tag_o, load_data_o,
                                            exp_tag_q[0], exp_data_q[0]));
            void'(exp_tag_q.pop_front());
            void'(exp_data_q.pop_front());
        end
    end

    always @(negedge clk_i) begin
        assert (UUT.u_lsq.u_lsq_assert.fail_count == 0)
            else report_error("a concurrent assertion on the load/store queue failed");
    end

    task automatic send_instr(input mem_op_t op, input logic [ADDR_W-1:0] addr,
                              input logic [DATA_W-1:0] wdata, input logic [TAG_W-1:0] tag);
        while (full_o) @(negedge clk_i);   // Core holds the instruction
        instr_valid_i = 1'b1;
        instr_op_i    = op;
        instr_addr_i  = addr;
        instr_wdata_i = wdata;
        instr_tag_i   = tag;
        @(negedge clk_i);
        instr_valid_i = 1'b0;
    endtask

    task automatic send_load(input logic [ADDR_W-1:0] addr, input logic [TAG_W-1:0] tag,
                             input logic [DATA_W-1:0] exp_data);
        exp_tag_q.push_back(tag);
        exp_data_q.push_back(exp_data);
        send_instr(MEM_LOAD, addr, '0, tag);
    endtask

    task automatic commit_store(input logic [TAG_W-1:0] tag, input logic [ADDR_W-1:0] addr,
                                input logic [DATA_W-1:0] data);
        commit_valid_i = 1'b1;
        commit_tag_i   = tag;
        ref_mem[addr]  = data;
        @(negedge clk_i);
        commit_valid_i = 1'b0;
    endtask

    task automatic flush_queue();
        flush_i = 1'b1;
        @(negedge clk_i);
        flush_i = 1'b0;
        @(negedge clk_i);
    endtask

    task automatic wait_results();
        while (exp_tag_q.size() != 0) @(negedge clk_i);
    endtask

    task automatic wait_drain();
        while (!empty_o) @(negedge clk_i);
        repeat (3) @(negedge clk_i);   // Last store still holds the bus for two cycles
    endtask

    task automatic check_reset_state();
        assert (!full_o && empty_o && !load_valid_o && !load_after_store_o)
            else report_error("status outputs wrong after reset");
        assert (!UUT.wb_cyc && !UUT.wb_stb)
            else report_error("Wishbone cycle active after reset");
    endtask

    task automatic test_store_commit_load();
        logic [TAG_W-1:0]  st_tag;
        logic [TAG_W-1:0]  ld_tag;
        logic [31:0]       data;
        take_bits(32, data);
        new_tag(st_tag);
        send_instr(MEM_STORE, 8'h10, data, st_tag);
        commit_store(st_tag, 8'h10, data);
        wait_drain();
        new_tag(ld_tag);
        send_load(8'h10, ld_tag, ref_mem[8'h10]);
        // Head one cycle after the write, then two strobe cycles and the result pulse
        repeat (2) begin
            @(negedge clk_i);
            assert (!load_valid_o) else report_error("load result arrived too early");
        end
        @(negedge clk_i);
        assert (load_valid_o) else report_error("load result missing 3 cycles after issue");
        wait_results();
    endtask

    task automatic test_blocked_load();
        logic [TAG_W-1:0] st_tag;
        logic [TAG_W-1:0] ld_tag;
        logic [31:0]      data;
        take_bits(32, data);
        new_tag(st_tag);
        send_instr(MEM_STORE, 8'h18, data, st_tag);
        new_tag(ld_tag);
        send_load(8'h18, ld_tag, data);
        while (!load_after_store_o) @(negedge clk_i);
        repeat (4) begin
            @(negedge clk_i);
            assert (load_after_store_o && !load_valid_o)
                else report_error("colliding load went ahead of its uncommitted store");
        end
        commit_store(st_tag, 8'h18, data);
        wait_results();
        assert (!load_after_store_o) else report_error("load_after_store stuck high");
        wait_drain();
    endtask

    task automatic test_load_passes_store();
        logic [TAG_W-1:0] st_tag;
        logic [TAG_W-1:0] ld_tag;
        logic [31:0]      data;
        take_bits(32, data);
        new_tag(st_tag);
        send_instr(MEM_STORE, 8'h11, data, st_tag);
        new_tag(ld_tag);
        send_load(8'h10, ld_tag, ref_mem[8'h10]);
        wait_results();   // Store is still uncommitted here
        commit_store(st_tag, 8'h11, data);
        wait_drain();
    endtask

    task automatic test_full_queue();
        logic [TAG_W-1:0] tags [SB_ENTRIES+LSQ_ENTRIES];
        logic [31:0]      vals [SB_ENTRIES+LSQ_ENTRIES];
        logic [TAG_W-1:0] ld_tag;
        for (int i = 0; i < SB_ENTRIES + LSQ_ENTRIES; i++) begin
            take_bits(32, vals[i]);
            new_tag(tags[i]);
            send_instr(MEM_STORE, ADDR_W'(8'h40 + i), vals[i], tags[i]);
        end
        assert (full_o) else report_error("full_o low with store buffer and queue full");
        for (int i = 0; i < SB_ENTRIES + LSQ_ENTRIES; i++) begin
            commit_store(tags[i], ADDR_W'(8'h40 + i), vals[i]);
        end
        while (full_o) @(negedge clk_i);
        wait_drain();
        for (int i = 0; i < SB_ENTRIES + LSQ_ENTRIES; i++) begin
            new_tag(ld_tag);
            send_load(ADDR_W'(8'h40 + i), ld_tag, ref_mem[ADDR_W'(8'h40 + i)]);
        end
        wait_results();
    endtask

    task automatic test_flush();
        logic [TAG_W-1:0] t1;
        logic [TAG_W-1:0] t2;
        logic [TAG_W-1:0] t3;
        logic [31:0]      d1;
        logic [31:0]      d2;
        take_bits(32, d1);
        take_bits(32, d2);
        new_tag(t1);
        new_tag(t2);
        new_tag(t3);
        send_instr(MEM_STORE, 8'h12, d1, t1);
        send_instr(MEM_STORE, 8'h10, d2, t2);
        send_instr(MEM_LOAD, 8'h10, '0, t3);   // Blocked behind t2, dropped by the flush
        commit_store(t1, 8'h12, d1);
        flush_queue();
        wait_drain();
        flush_queue();   // Flush with nothing queued holds full and empty high together
        assert (empty_o && !full_o) else report_error("idle flush left the queue busy");
        new_tag(t3);
        send_load(8'h10, t3, ref_mem[8'h10]);
        new_tag(t3);
        send_load(8'h12, t3, ref_mem[8'h12]);
        wait_results();
    endtask

    task automatic test_random_sequence();
        logic [31:0]       op_bit;
        logic [31:0]       offset;
        logic [31:0]       data;
        logic [ADDR_W-1:0] addr;
        logic [TAG_W-1:0]  tag;
        for (int i = 0; i < RAND_OPS; i++) begin
            take_bits(1, op_bit);
            take_bits(3, offset);
            addr = 8'h20 + ADDR_W'(offset[2:0]);   // Small window so loads hit stores
            new_tag(tag);
            if (op_bit[0]) begin
                take_bits(32, data);
                send_instr(MEM_STORE, addr, data, tag);
                commit_store(tag, addr, data);
            end else begin
                send_load(addr, tag, ref_mem[addr]);
            end
        end
        wait_results();
        wait_drain();
    endtask

    initial begin
        rstn_i         = 1'b0;
        instr_valid_i  = 1'b0;
        instr_op_i     = MEM_LOAD;
        instr_addr_i   = '0;
        instr_wdata_i  = '0;
        instr_tag_i    = '0;
        commit_valid_i = 1'b0;
        commit_tag_i   = '0;
        flush_i        = 1'b0;
        lfsr_q         = 32'hb94e_31bb;
        next_tag       = '0;
        for (int i = 0; i < 2**ADDR_W; i++) begin
            ref_mem[i] = '0;
        end
        repeat (2) @(negedge clk_i);
        rstn_i = 1'b1;
        check_reset_state();

        test_store_commit_load();
        test_blocked_load();
        test_load_passes_store();
        test_full_queue();
        test_flush();
        test_random_sequence();

        repeat (2) @(negedge clk_i);
        if (UUT.u_lsq.u_lsq_assert.fail_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Concurrent assertions failed %0d times",
                     UUT.u_lsq.u_lsq_assert.fail_count);
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
hdl/lsq_pkg.sv
hdl/mem_circ_queue.sv
hdl/store_buffer.sv
hdl/load_store_queue.sv
hdl/mem_wb_master.sv
hdl/data_ram.sv
hdl/lsq_top.sv
tests/lsq_assert.sv
tests/tb_lsq_top.sv

// ==== Bender.yml ====
package:
  name: lsq

sources:
  - files:
      - hdl/lsq_pkg.sv
      - hdl/mem_circ_queue.sv
      - hdl/store_buffer.sv
      - hdl/load_store_queue.sv
      - hdl/mem_wb_master.sv
      - hdl/data_ram.sv
      - hdl/lsq_top.sv
  - target: test
    files:
      - tests/lsq_assert.sv
      - tests/tb_lsq_top.sv
